// File: logic/isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [3:0]  byte_en_t;

	localparam int NUM_REGS = 32;

	////////////////////////////////////////////////////////////
	// opcodes
	////////////////////////////////////////////////////////////
	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_BEQ     = 6'h04;
	localparam opcode_t OP_BNE     = 6'h05;
	localparam opcode_t OP_ADDIU   = 6'h09;
	localparam opcode_t OP_LUI     = 6'h0f;
	localparam opcode_t OP_LW      = 6'h23;
	localparam opcode_t OP_SW      = 6'h2b;

	////////////////////////////////////////////////////////////
	// function codes under OP_SPECIAL
	////////////////////////////////////////////////////////////
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_SLT  = 6'h2a;

endpackage

// File: logic/pipe_pkg.sv
package pipe_pkg;

	import isa_pkg::*;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} alu_op_t;

	typedef enum logic {
		OPB_REG,
		OPB_IMM
	} operand_b_t;

	typedef enum logic [1:0] {
		FWD_RF,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	////////////////////////////////////////////////////////////
	// stage boundary payloads
	////////////////////////////////////////////////////////////
	typedef struct packed {
		word_t pc;
		word_t inst;
	} fd_payload_t;

	typedef struct packed {
		word_t      pc;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   dest;
		word_t      src_a;
		word_t      src_b;
		word_t      imm;
		alu_op_t    alu_op;
		operand_b_t b_sel;
		logic       load;
		logic       store;
		logic       reg_write;
	} de_payload_t;

	// load and reg_write are already cleared for bubbles
	typedef struct packed {
		word_t    pc;
		reg_idx_t dest;
		word_t    alu_result;
		logic     load;
		logic     reg_write;
	} em_payload_t;

	typedef struct packed {
		em_payload_t em;
		word_t       rdata;
	} mw_payload_t;

	// shared operand mux for decode and execute forwarding
	function automatic word_t fwd_pick(fwd_sel_t sel, word_t rf, word_t mem, word_t wb);
		case (sel)
			FWD_MEM: return mem;
			FWD_WB:  return wb;
			default: return rf;
		endcase
	endfunction

endpackage

// File: logic/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     stall,
	input  logic     in_valid,
	input  logic     next_allowin,
	input  payload_t in_data,
	output logic     allowin,
	output logic     out_valid,
	output payload_t out_data,
	output logic     full
);

	// empty, or moving on this cycle
	assign allowin = !full || (next_allowin && !stall);

	// a stalled stage sends a bubble
	assign out_valid = full && !stall;

	always_ff @(posedge clk) begin
		if (rst) begin
			full <= 1'b0;
		end else if (allowin) begin
			full <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (allowin) begin
			out_data <= in_data;
		end
	end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter isa_pkg::word_t RESET_PC = '0
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stall,
	input  logic                  take_branch,
	input  isa_pkg::word_t        branch_target,
	input  logic                  next_allowin,
	input  isa_pkg::word_t        inst_sram_rdata,
	output logic                  inst_sram_en,
	output isa_pkg::word_t        inst_sram_addr,
	output logic                  out_valid,
	output pipe_pkg::fd_payload_t fd_data
);

	import isa_pkg::*;

	logic  valid;
	logic  accept;
	word_t pc;
	word_t next_pc;

	assign accept  = !valid || (next_allowin && !stall);
	assign next_pc = take_branch ? branch_target : pc + 32'd4;

	// the SRAM keeps its last word while fetch waits
	assign inst_sram_en   = accept;
	assign inst_sram_addr = next_pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
			pc    <= RESET_PC - 32'd4;
		end else if (accept) begin
			valid <= 1'b1;
			pc    <= next_pc;
		end
	end

	assign out_valid = valid;
	assign fd_data   = '{pc: pc, inst: inst_sram_rdata};

endmodule

// File: logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
	input  logic                  valid,
	input  pipe_pkg::fd_payload_t fd_data,
	input  isa_pkg::word_t        rf_a,
	input  isa_pkg::word_t        rf_b,
	input  isa_pkg::word_t        mem_result,
	input  isa_pkg::word_t        wb_data,
	input  pipe_pkg::fwd_sel_t    fwd_a,
	input  pipe_pkg::fwd_sel_t    fwd_b,
	output isa_pkg::reg_idx_t     rs,
	output isa_pkg::reg_idx_t     rt,
	output logic                  take_branch,
	output logic                  is_branch,
	output isa_pkg::word_t        branch_target,
	output logic                  uses_rt,
	output pipe_pkg::de_payload_t de_data
);

	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_t    op;
	funct_t     funct;
	reg_idx_t   rd;
	word_t      imm_ext;
	word_t      src_a;
	word_t      src_b;
	alu_op_t    alu_op;
	operand_b_t b_sel;
	logic       load;
	logic       store;
	logic       reg_write;
	logic       dest_rd;

	assign op      = fd_data.inst[31:26];
	assign rs      = fd_data.inst[25:21];
	assign rt      = fd_data.inst[20:16];
	assign rd      = fd_data.inst[15:11];
	assign funct   = fd_data.inst[5:0];
	assign imm_ext = {{16{fd_data.inst[15]}}, fd_data.inst[15:0]};

	////////////////////////////////////////////////////////////
	// control word
	////////////////////////////////////////////////////////////
	always_comb begin
		alu_op    = ALU_ADD;
		b_sel     = OPB_IMM;
		load      = 1'b0;
		store     = 1'b0;
		reg_write = 1'b0;
		dest_rd   = 1'b0;
		uses_rt   = 1'b0;
		is_branch = 1'b0;
		case (op)
			OP_SPECIAL: begin
				b_sel     = OPB_REG;
				dest_rd   = 1'b1;
				uses_rt   = 1'b1;
				reg_write = 1'b1;
				case (funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					// nop and anything unsupported
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: reg_write = 1'b1;
			OP_LUI: begin
				alu_op    = ALU_LUI;
				reg_write = 1'b1;
			end
			OP_LW: begin
				load      = 1'b1;
				reg_write = 1'b1;
			end
			OP_SW: begin
				store   = 1'b1;
				uses_rt = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				is_branch = 1'b1;
				uses_rt   = 1'b1;
			end
			default: ;
		endcase
	end

	assign src_a = fwd_pick(fwd_a, rf_a, mem_result, wb_data);
	assign src_b = fwd_pick(fwd_b, rf_b, mem_result, wb_data);

	// resolved here, the delay slot is already in fetch
	assign take_branch = valid && (((op == OP_BEQ) && (src_a == src_b)) ||
		((op == OP_BNE) && (src_a != src_b)));
	assign branch_target = fd_data.pc + 32'd4 + {imm_ext[29:0], 2'b00};

	assign de_data = '{
		pc:        fd_data.pc,
		rs:        rs,
		rt:        rt,
		dest:      dest_rd ? rd : rt,
		src_a:     src_a,
		src_b:     src_b,
		imm:       imm_ext,
		alu_op:    alu_op,
		b_sel:     b_sel,
		load:      load,
		store:     store,
		reg_write: reg_write
	};

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  logic                  valid,
	input  pipe_pkg::de_payload_t de_data,
	input  isa_pkg::word_t        mem_result,
	input  isa_pkg::word_t        wb_data,
	input  pipe_pkg::fwd_sel_t    fwd_a,
	input  pipe_pkg::fwd_sel_t    fwd_b,
	output logic                  data_sram_en,
	output isa_pkg::byte_en_t     data_sram_wen,
	output isa_pkg::word_t        data_sram_addr,
	output isa_pkg::word_t        data_sram_wdata,
	output pipe_pkg::em_payload_t em_data
);

	import isa_pkg::*;
	import pipe_pkg::*;

	word_t op_a;
	word_t rt_val;
	word_t op_b;
	word_t result;

	assign op_a   = fwd_pick(fwd_a, de_data.src_a, mem_result, wb_data);
	assign rt_val = fwd_pick(fwd_b, de_data.src_b, mem_result, wb_data);
	assign op_b   = (de_data.b_sel == OPB_IMM) ? de_data.imm : rt_val;

	always_comb begin
		case (de_data.alu_op)
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_LUI: result = {op_b[15:0], 16'h0000};
			default: result = op_a + op_b;
		endcase
	end

	// word stores only
	assign data_sram_en    = 1'b1;
	assign data_sram_wen   = {4{valid && de_data.store}};
	assign data_sram_addr  = result;
	assign data_sram_wdata = rt_val;

	assign em_data = '{
		pc:         de_data.pc,
		dest:       de_data.dest,
		alu_result: result,
		load:       valid && de_data.load,
		reg_write:  valid && de_data.reg_write
	};

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input  isa_pkg::reg_idx_t     dec_rs,
	input  isa_pkg::reg_idx_t     dec_rt,
	input  logic                  dec_branch,
	input  logic                  dec_uses_rt,
	input  logic                  dec_valid,
	input  pipe_pkg::de_payload_t exe_data,
	input  logic                  exe_valid,
	input  isa_pkg::reg_idx_t     mem_dest,
	input  isa_pkg::reg_idx_t     wb_dest,
	input  logic                  mem_wen,
	input  logic                  mem_load,
	input  logic                  wb_wen,
	output pipe_pkg::fwd_sel_t    dec_fwd_a,
	output pipe_pkg::fwd_sel_t    dec_fwd_b,
	output pipe_pkg::fwd_sel_t    exe_fwd_a,
	output pipe_pkg::fwd_sel_t    exe_fwd_b,
	output logic                  dec_stall
);

	import isa_pkg::*;
	import pipe_pkg::*;

	logic exe_writes;
	logic exe_hit_a;
	logic exe_hit_b;
	logic mem_load_hit;
	logic load_use;
	logic branch_dep;

	// nearest writer wins, r0 is never forwarded
	function automatic fwd_sel_t pick_source(reg_idx_t src, logic m_wen, reg_idx_t m_dest,
		logic w_wen, reg_idx_t w_dest);
		if (m_wen && (m_dest != '0) && (m_dest == src)) begin
			return FWD_MEM;
		end
		if (w_wen && (w_dest != '0) && (w_dest == src)) begin
			return FWD_WB;
		end
		return FWD_RF;
	endfunction

	assign dec_fwd_a = pick_source(dec_rs, mem_wen, mem_dest, wb_wen, wb_dest);
	assign dec_fwd_b = pick_source(dec_rt, mem_wen, mem_dest, wb_wen, wb_dest);
	assign exe_fwd_a = pick_source(exe_data.rs, mem_wen, mem_dest, wb_wen, wb_dest);
	assign exe_fwd_b = pick_source(exe_data.rt, mem_wen, mem_dest, wb_wen, wb_dest);

	////////////////////////////////////////////////////////////
	// stall decision
	////////////////////////////////////////////////////////////
	assign exe_writes = exe_valid && exe_data.reg_write && (exe_data.dest != '0);
	assign exe_hit_a  = exe_writes && (exe_data.dest == dec_rs);
	assign exe_hit_b  = exe_writes && dec_uses_rt && (exe_data.dest == dec_rt);

	// the read word is too late for the branch compare
	assign mem_load_hit = mem_wen && mem_load && (mem_dest != '0) &&
		((mem_dest == dec_rs) || (dec_uses_rt && (mem_dest == dec_rt)));

	assign load_use   = exe_data.load && (exe_hit_a || exe_hit_b);
	assign branch_dep = dec_branch && (exe_hit_a || exe_hit_b || mem_load_hit);
	assign dec_stall  = dec_valid && (load_use || branch_dep);

endmodule

// File: logic/writeback_regfile.sv
`timescale 1ns/1ps

module writeback_regfile (
	input  logic                  clk,
	input  logic                  valid,
	input  pipe_pkg::mw_payload_t mw_data,
	input  isa_pkg::reg_idx_t     rs,
	input  isa_pkg::reg_idx_t     rt,
	output isa_pkg::word_t        rf_a,
	output isa_pkg::word_t        rf_b,
	output isa_pkg::word_t        wb_data,
	output isa_pkg::reg_idx_t     wb_dest,
	output logic                  wb_wen,
	output isa_pkg::word_t        debug_wb_pc,
	output isa_pkg::byte_en_t     debug_wb_rf_wen,
	output isa_pkg::reg_idx_t     debug_wb_rf_wnum,
	output isa_pkg::word_t        debug_wb_rf_wdata
);

	import isa_pkg::*;

	word_t regs [NUM_REGS];

	assign wb_dest = mw_data.em.dest;
	assign wb_wen  = valid && mw_data.em.reg_write;
	assign wb_data = mw_data.em.load ? mw_data.rdata : mw_data.em.alu_result;

	always_ff @(posedge clk) begin
		if (wb_wen && (wb_dest != '0)) begin
			regs[wb_dest] <= wb_data;
		end
	end

	// no bypass, same-cycle values arrive through forwarding
	assign rf_a = (rs == '0) ? '0 : regs[rs];
	assign rf_b = (rt == '0) ? '0 : regs[rt];

	// trace shows r0 writes too
	assign debug_wb_pc       = mw_data.em.pc;
	assign debug_wb_rf_wen   = {4{wb_wen}};
	assign debug_wb_rf_wnum  = wb_dest;
	assign debug_wb_rf_wdata = wb_data;

endmodule

// File: logic/mips_core.sv
`timescale 1ns/1ps

module mips_core #(
	parameter isa_pkg::word_t RESET_PC = '0
) (
	input  logic              clk,
	input  logic              rst,
	output logic              inst_sram_en,
	output isa_pkg::word_t    inst_sram_addr,
	input  isa_pkg::word_t    inst_sram_rdata,
	output logic              data_sram_en,
	output isa_pkg::byte_en_t data_sram_wen,
	output isa_pkg::word_t    data_sram_addr,
	output isa_pkg::word_t    data_sram_wdata,
	input  isa_pkg::word_t    data_sram_rdata,
	output isa_pkg::word_t    debug_wb_pc,
	output isa_pkg::byte_en_t debug_wb_rf_wen,
	output isa_pkg::reg_idx_t debug_wb_rf_wnum,
	output isa_pkg::word_t    debug_wb_rf_wdata
);

	import isa_pkg::*;
	import pipe_pkg::*;

	logic        f_valid, fd_allowin, fd_valid, fd_full;
	logic        de_allowin, de_valid, em_allowin, em_valid, mw_allowin, mw_valid;
	fd_payload_t f_data, fd_data;
	de_payload_t d_data, de_data;
	em_payload_t e_data, em_data;
	mw_payload_t mw_in, mw_data;

	logic        dec_stall, take_branch, is_branch, uses_rt, wb_wen;
	word_t       branch_target, rf_a, rf_b, mem_result, wb_data;
	reg_idx_t    dec_rs, dec_rt, wb_dest;
	fwd_sel_t    dec_fwd_a, dec_fwd_b, exe_fwd_a, exe_fwd_b;

	assign mem_result = em_data.alu_result;
	// read word joins the payload at the memory/writeback boundary
	assign mw_in = '{em: em_data, rdata: data_sram_rdata};

	////////////////////////////////////////////////////////////
	// fetch and decode
	////////////////////////////////////////////////////////////
	fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk), .rst(rst), .stall(dec_stall), .take_branch(take_branch),
		.branch_target(branch_target), .next_allowin(fd_allowin),
		.inst_sram_rdata(inst_sram_rdata), .inst_sram_en(inst_sram_en),
		.inst_sram_addr(inst_sram_addr), .out_valid(f_valid), .fd_data(f_data)
	);

	pipe_stage #(.payload_t(fd_payload_t)) u_fd (
		.clk(clk), .rst(rst), .stall(dec_stall), .in_valid(f_valid),
		.next_allowin(de_allowin), .in_data(f_data), .allowin(fd_allowin),
		.out_valid(fd_valid), .out_data(fd_data), .full(fd_full)
	);

	decode_unit u_decode (
		.valid(fd_full), .fd_data(fd_data), .rf_a(rf_a), .rf_b(rf_b),
		.mem_result(mem_result), .wb_data(wb_data), .fwd_a(dec_fwd_a), .fwd_b(dec_fwd_b),
		.rs(dec_rs), .rt(dec_rt), .take_branch(take_branch), .is_branch(is_branch),
		.branch_target(branch_target), .uses_rt(uses_rt), .de_data(d_data)
	);

	////////////////////////////////////////////////////////////
	// execute, memory, writeback
	////////////////////////////////////////////////////////////
	pipe_stage #(.payload_t(de_payload_t)) u_de (
		.clk(clk), .rst(rst), .stall(1'b0), .in_valid(fd_valid),
		.next_allowin(em_allowin), .in_data(d_data), .allowin(de_allowin),
		.out_valid(de_valid), .out_data(de_data), .full()
	);

	execute_unit u_execute (
		.valid(de_valid), .de_data(de_data), .mem_result(mem_result), .wb_data(wb_data),
		.fwd_a(exe_fwd_a), .fwd_b(exe_fwd_b), .data_sram_en(data_sram_en),
		.data_sram_wen(data_sram_wen), .data_sram_addr(data_sram_addr),
		.data_sram_wdata(data_sram_wdata), .em_data(e_data)
	);

	pipe_stage #(.payload_t(em_payload_t)) u_em (
		.clk(clk), .rst(rst), .stall(1'b0), .in_valid(de_valid),
		.next_allowin(mw_allowin), .in_data(e_data), .allowin(em_allowin),
		.out_valid(em_valid), .out_data(em_data), .full()
	);

	pipe_stage #(.payload_t(mw_payload_t)) u_mw (
		.clk(clk), .rst(rst), .stall(1'b0), .in_valid(em_valid),
		.next_allowin(1'b1), .in_data(mw_in), .allowin(mw_allowin),
		.out_valid(mw_valid), .out_data(mw_data), .full()
	);

	writeback_regfile u_writeback (
		.clk(clk), .valid(mw_valid), .mw_data(mw_data), .rs(dec_rs), .rt(dec_rt),
		.rf_a(rf_a), .rf_b(rf_b), .wb_data(wb_data), .wb_dest(wb_dest), .wb_wen(wb_wen),
		.debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
		.debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
	);

	hazard_unit u_hazard (
		.dec_rs(dec_rs), .dec_rt(dec_rt), .dec_branch(is_branch), .dec_uses_rt(uses_rt),
		.dec_valid(fd_full), .exe_data(de_data), .exe_valid(de_valid),
		.mem_dest(em_data.dest), .wb_dest(wb_dest), .mem_wen(em_data.reg_write),
		.mem_load(em_data.load), .wb_wen(wb_wen), .dec_fwd_a(dec_fwd_a),
		.dec_fwd_b(dec_fwd_b), .exe_fwd_a(exe_fwd_a), .exe_fwd_b(exe_fwd_b),
		.dec_stall(dec_stall)
	);

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release just after an edge, like every other input
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// File: verification/mips_core_asserts.sv
`timescale 1ns/1ps

module mips_core_asserts (
	input logic              clk,
	input logic              rst,
	input logic              f_valid,
	input logic              fd_full,
	input logic              fd_valid,
	input logic              de_valid,
	input logic              em_valid,
	input logic              mw_valid,
	input logic              mem_writes,
	input isa_pkg::byte_en_t data_sram_wen,
	input isa_pkg::byte_en_t debug_wb_rf_wen
);

	// empty stages fill, and stages past decode never hold
	stages_take_input: assert property (@(posedge clk) disable iff (rst)
		($past(fd_full) || (fd_full == $past(f_valid))) &&
		(de_valid == $past(fd_valid)) && (em_valid == $past(de_valid)) &&
		(mw_valid == $past(em_valid)))
		else $error("a pipeline stage did not take the input offered to it");

	no_store_in_reset: assert property (@(posedge clk)
		(rst && $past(rst)) |-> (data_sram_wen == '0))
		else $error("data SRAM write enabled during reset");

	// whole-word trace enable for the writer that left memory
	trace_wen_whole: assert property (@(posedge clk) disable iff (rst)
		debug_wb_rf_wen == {4{$past(mem_writes)}})
		else $error("trace write enable does not match the writer leaving memory");

endmodule

bind mips_core mips_core_asserts u_mips_core_asserts (
	.clk(clk),
	.rst(rst),
	.f_valid(f_valid),
	.fd_full(fd_full),
	.fd_valid(fd_valid),
	.de_valid(de_valid),
	.em_valid(em_valid),
	.mw_valid(mw_valid),
	.mem_writes(em_valid && em_data.reg_write),
	.data_sram_wen(data_sram_wen),
	.debug_wb_rf_wen(debug_wb_rf_wen)
);

// File: verification/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb;

	import isa_pkg::*;

	localparam word_t RESET_PC   = 32'h0000_0040;
	localparam int    IMEM_WORDS = 128;
	localparam int    DMEM_WORDS = 256;
	localparam int    WAIT_LIMIT = 40;

	logic     clk;
	logic     rst;
	logic     inst_sram_en;
	word_t    inst_sram_addr;
	word_t    inst_sram_rdata;
	logic     data_sram_en;
	byte_en_t data_sram_wen;
	word_t    data_sram_addr;
	word_t    data_sram_wdata;
	word_t    data_sram_rdata;
	word_t    debug_wb_pc;
	byte_en_t debug_wb_rf_wen;
	reg_idx_t debug_wb_rf_wnum;
	word_t    debug_wb_rf_wdata;

	word_t imem [IMEM_WORDS];
	word_t dmem [DMEM_WORDS];
	int    seed;
	int    prog_len;
	int    cycle_count = 0;

	// expected register writes in retirement order, and expected stores
	word_t    exp_pc [$];
	reg_idx_t exp_num [$];
	word_t    exp_val [$];
	int       exp_slot [$];
	word_t    st_addr [$];
	word_t    st_data [$];

	tb_clock #(.PERIOD(8), .RESET_CYCLES(5)) u_clock (.clk(clk), .rst(rst));

	mips_core #(.RESET_PC(RESET_PC)) u_mips_core (
		.clk(clk), .rst(rst),
		.inst_sram_en(inst_sram_en), .inst_sram_addr(inst_sram_addr),
		.inst_sram_rdata(inst_sram_rdata),
		.data_sram_en(data_sram_en), .data_sram_wen(data_sram_wen),
		.data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
		.data_sram_rdata(data_sram_rdata),
		.debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
		.debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
	);

	////////////////////////////////////////////////////////////
	// SRAM models with one cycle read latency
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (inst_sram_en) begin
			inst_sram_rdata <= #1 imem[inst_sram_addr[8:2]];
		end
	end

	always @(posedge clk) begin
		int lane;
		data_sram_rdata <= #1 dmem[data_sram_addr[9:2]];
		for (lane = 0; lane < 4; lane++) begin
			if (data_sram_wen[lane]) begin
				dmem[data_sram_addr[9:2]][8 * lane +: 8] <= data_sram_wdata[8 * lane +: 8];
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	////////////////////////////////////////////////////////////
	// reporting and compares
	////////////////////////////////////////////////////////////
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_wen(input string name, input byte_en_t got, input byte_en_t exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_en(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////
	// program table
	////////////////////////////////////////////////////////////
	function automatic word_t rtype(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t itype(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] random_imm();
		word_t r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// depends on every address bit
	function automatic word_t fill_word(input int idx);
		word_t addr;
		addr = idx << 2;
		return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
	endfunction

	task automatic append_inst(input word_t w);
		imem[RESET_PC[8:2] + prog_len] = w;
		prog_len++;
	endtask

	task automatic load_program();
		logic [15:0] off;
		logic [15:0] off2;
		off  = random_imm() & 16'h00fc;
		off2 = off ^ 16'h0040;
		// alu chain where each result is used right away
		append_inst(itype(OP_ADDIU, 0, 1, random_imm()));
		append_inst(itype(OP_ADDIU, 1, 2, random_imm()));
		append_inst(itype(OP_LUI, 0, 3, random_imm()));
		append_inst(rtype(FN_ADDU, 2, 3, 4));
		append_inst(rtype(FN_SUBU, 4, 1, 5));
		append_inst(rtype(FN_AND, 5, 4, 6));
		append_inst(rtype(FN_OR, 6, 2, 7));
		append_inst(rtype(FN_SLT, 7, 5, 8));
		append_inst(rtype(FN_SLT, 5, 7, 9));
		// store, reload, load-use
		append_inst(itype(OP_ADDIU, 0, 10, 16'h0100));
		append_inst(itype(OP_SW, 10, 7, off));
		append_inst(itype(OP_LW, 10, 11, off));
		append_inst(rtype(FN_ADDU, 11, 4, 12));
		append_inst(itype(OP_LW, 10, 13, off2));
		append_inst(rtype(FN_OR, 13, 1, 14));
		// taken beq skips two words
		append_inst(rtype(FN_ADDU, 12, 0, 15));
		append_inst(itype(OP_BEQ, 15, 12, 16'd3));
		append_inst(itype(OP_ADDIU, 0, 16, random_imm()));
		append_inst(itype(OP_ADDIU, 0, 17, 16'd1));
		append_inst(itype(OP_ADDIU, 0, 17, 16'd2));
		append_inst(itype(OP_ADDIU, 16, 18, random_imm()));
		// bne on a fresh load falls through
		append_inst(itype(OP_LW, 10, 19, off));
		append_inst(itype(OP_BNE, 19, 7, 16'd5));
		append_inst(itype(OP_ADDIU, 19, 20, random_imm()));
		append_inst(itype(OP_ADDIU, 20, 21, random_imm()));
		// r0 as destination
		append_inst(itype(OP_ADDIU, 1, 0, random_imm()));
		append_inst(rtype(FN_ADDU, 0, 2, 22));
		append_inst(rtype(FN_OR, 0, 0, 23));
	endtask

	////////////////////////////////////////////////////////////
	// in-order reference model
	////////////////////////////////////////////////////////////
	task automatic run_reference();
		word_t    regs [NUM_REGS];
		word_t    ref_dmem [DMEM_WORDS];
		word_t    pc, npc, inst, a, b, imm, addr, result;
		opcode_t  op;
		reg_idx_t rs, rt, dest, d1, d2;
		logic     writes, is_load, is_branch, reads_rt, taken, hit1, hit2, l1, l2;
		int       i, bubbles, b1, slot, steps;
		for (i = 0; i < DMEM_WORDS; i++) begin
			ref_dmem[i] = fill_word(i);
		end
		pc    = RESET_PC;
		npc   = RESET_PC + 32'd4;
		d1    = '0;
		d2    = '0;
		l1    = 1'b0;
		l2    = 1'b0;
		b1    = 0;
		slot  = 0;
		steps = 0;
		while ((pc != RESET_PC + 4 * prog_len) && (steps < 100)) begin
			inst      = imem[pc[8:2]];
			op        = inst[31:26];
			rs        = inst[25:21];
			rt        = inst[20:16];
			imm       = {{16{inst[15]}}, inst[15:0]};
			a         = (rs == 0) ? '0 : regs[rs];
			b         = (rt == 0) ? '0 : regs[rt];
			addr      = a + imm;
			is_load   = (op == OP_LW);
			is_branch = (op == OP_BEQ) || (op == OP_BNE);
			reads_rt  = (op == OP_SPECIAL) || (op == OP_SW) || is_branch;
			// bubbles from load-use and branch dependences
			hit1 = (d1 != 0) && ((d1 == rs) || (reads_rt && (d1 == rt)));
			hit2 = (d2 != 0) && ((d2 == rs) || (reads_rt && (d2 == rt)));
			bubbles = 0;
			if (is_branch) begin
				if (hit1) begin
					bubbles = l1 ? 2 : 1;
				end else if (hit2 && l2 && (b1 == 0)) begin
					bubbles = 1;
				end
			end else if (hit1 && l1) begin
				bubbles = 1;
			end
			slot   += 1 + bubbles;
			writes = 1'b1;
			dest   = rt;
			result = addr;
			case (op)
				OP_SPECIAL: begin
					dest = inst[15:11];
					case (inst[5:0])
						FN_ADDU: result = a + b;
						FN_SUBU: result = a - b;
						FN_AND:  result = a & b;
						FN_OR:   result = a | b;
						FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				OP_ADDIU: result = addr;
				OP_LUI:   result = {inst[15:0], 16'h0000};
				OP_LW:    result = ref_dmem[addr[9:2]];
				OP_SW: begin
					writes = 1'b0;
					ref_dmem[addr[9:2]] = b;
					st_addr.push_back(addr);
					st_data.push_back(b);
				end
				default: writes = 1'b0;
			endcase
			if (writes) begin
				exp_pc.push_back(pc);
				exp_num.push_back(dest);
				exp_val.push_back(result);
				exp_slot.push_back(slot);
				if (dest != 0) begin
					regs[dest] = result;
				end
			end
			taken = ((op == OP_BEQ) && (a == b)) || ((op == OP_BNE) && (a != b));
			d2 = d1;
			l2 = l1;
			d1 = writes ? dest : '0;
			l1 = is_load;
			b1 = bubbles;
			// delay slot runs before the target
			pc  = npc;
			npc = taken ? (pc + {imm[29:0], 2'b00}) : (npc + 32'd4);
			steps++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////
	task automatic check_reset();
		int waited;
		waited = 0;
		@(posedge clk);
		@(negedge clk);
		while (rst) begin
			check_wen("data_sram_wen", data_sram_wen, '0);
			check_wen("debug_wb_rf_wen", debug_wb_rf_wen, '0);
			waited++;
			if (waited > WAIT_LIMIT) begin
				fail_run("reset was never released");
			end
			@(negedge clk);
		end
		// first cycle out of reset
		check_wen("data_sram_wen", data_sram_wen, '0);
		check_wen("debug_wb_rf_wen", debug_wb_rf_wen, '0);
		check_en("inst_sram_en", inst_sram_en, 1'b1);
		check_word("inst_sram_addr", inst_sram_addr, RESET_PC);
	endtask

	task automatic check_writes();
		int n;
		int waited;
		int first_cycle;
		first_cycle = 0;
		for (n = 0; n < exp_num.size(); n++) begin
			waited = 0;
			@(negedge clk);
			while (debug_wb_rf_wen == '0) begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					fail_run($sformatf("timed out waiting for register write %0d", n));
				end
				@(negedge clk);
			end
			check_wen("debug_wb_rf_wen", debug_wb_rf_wen, '1);
			check_word("debug_wb_pc", debug_wb_pc, exp_pc[n]);
			check_reg("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_num[n]);
			check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[n]);
			if (n == 0) begin
				first_cycle = cycle_count;
			end else begin
				check_word("retire_cycle", word_t'(cycle_count - first_cycle),
					word_t'(exp_slot[n] - exp_slot[0]));
			end
		end
	endtask

	task automatic check_stores();
		int n;
		int waited;
		for (n = 0; n < st_addr.size(); n++) begin
			waited = 0;
			@(negedge clk);
			while (data_sram_wen == '0) begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					fail_run($sformatf("timed out waiting for store %0d", n));
				end
				@(negedge clk);
			end
			check_en("data_sram_en", data_sram_en, 1'b1);
			check_wen("data_sram_wen", data_sram_wen, '1);
			check_word("data_sram_addr", data_sram_addr, st_addr[n]);
			check_word("data_sram_wdata", data_sram_wdata, st_data[n]);
		end
	endtask

	// trailing nops write nothing
	task automatic check_quiet();
		repeat (10) begin
			@(negedge clk);
			check_wen("debug_wb_rf_wen", debug_wb_rf_wen, '0);
			check_wen("data_sram_wen", data_sram_wen, '0);
		end
	endtask

	initial begin
		int i;
		seed            = 40;
		prog_len        = 0;
		inst_sram_rdata = '0;
		data_sram_rdata = '0;
		for (i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = '0;
		end
		for (i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = fill_word(i);
		end
		load_program();
		run_reference();
		check_reset();
		fork
			check_writes();
			check_stores();
		join
		check_quiet();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: mips_core.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/pipe_stage.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/hazard_unit.sv
logic/writeback_regfile.sv
logic/mips_core.sv
verification/tb_clock.sv
verification/mips_core_asserts.sv
verification/mips_core_tb.sv
